// File: all.f
+incdir+src
+incdir+testbench
src/main_bus_pkg.sv
src/main_video_pkg.sv
src/main_decoder.sv
src/main_regs.sv
src/main_ram.sv
src/main_irq.sv
src/main_din_mux.sv
src/main_glue.sv
testbench/main_glue_tb.sv

// File: testbench/main_glue_tests.svh
/* Directed bus glue tests */

    // One CPU memory cycle held for three clocks
    task automatic bus_access(input logic [15:0] a, input logic write,
                              input logic [7:0] d, output logic [7:0] got);
        @(negedge clk);
        addr     = a;
        cpu_dout = d;
        wr_n     = !write;
        mreq_n   = 1'b0;
        repeat (3) @(negedge clk); // Read data lands two clocks after the address
        got    = cpu_din;
        mreq_n = 1'b1;
        wr_n   = 1'b1;
    endtask

    task automatic reset_defaults;
        check("reset int_n snd_int sres_b", 3'b111, {int_n, snd_int, sres_b});
        check("reset flip okout selects", 4'b0000, {flip, okout, char_cs, scr_cs});
        check("reset latch and scroll", 30'h0, {snd_latch, scr_hpos, scr_vpos});
    endtask

    task automatic reg_writes;
        logic [7:0] misc;
        logic [7:0] got;
        misc = 8'($urandom);
        bus_access(16'hc800, 1'b1, 8'ha5, got);
        check("snd_latch", 8'ha5, snd_latch);
        repeat (2) begin
            bus_access(16'hc804, 1'b1, misc, got);
            check("flip", misc[`MAIN_FLIP_BIT], flip);
            check("sres_b", !misc[`MAIN_SRES_BIT], sres_b); // Active low sound reset
            check("nmi_mask", misc[`MAIN_NMI_BIT], nmi_mask);
            misc = ~misc; // Each control bit takes both values
        end
        bus_access(16'hc808, 1'b1, 8'h34, got);
        bus_access(16'hc809, 1'b1, 8'h01, got);
        bus_access(16'hc80a, 1'b1, 8'hcd, got);
        bus_access(16'hc80b, 1'b1, 8'hfe, got); // Only bit 0 counts
        check("scr_hpos", 11'h134, scr_hpos);
        check("scr_vpos", 11'h0cd, scr_vpos);
        // okout is a level while the C806 write is on the bus
        @(negedge clk);
        addr   = 16'hc806;
        mreq_n = 1'b0;
        wr_n   = 1'b0;
        @(negedge clk);
        check("okout during write", 1'b1, okout);
        mreq_n = 1'b1;
        wr_n   = 1'b1;
        @(negedge clk);
        check("okout after write", 1'b0, okout);
    endtask

    task automatic ram_access;
        logic [15:0] a;
        logic [7:0]  d;
        logic [7:0]  got;
        repeat (8) begin
            a = {3'b111, 13'($urandom)};
            d = 8'($urandom);
            bus_access(a, 1'b1, d, got);
            bus_access(a, 1'b0, 8'h00, got);
            check("ram readback", d, got);
        end
        // Object scan owns the top page
        d = 8'($urandom);
        bus_access(16'hfe05, 1'b1, d, got);
        bus_access(16'hfe06, 1'b1, d ^ 8'h5a, got);
        blcnten  = 1'b1;
        obj_addr = 9'h005;
        bus_access(16'hfe06, 1'b1, ~d, got); // Must be dropped
        check("obj_dout", d, obj_dout);
        blcnten = 1'b0;
        bus_access(16'hfe06, 1'b0, 8'h00, got);
        check("ram after blocked write", d ^ 8'h5a, got);
    endtask

    task automatic read_mux;
        logic [7:0] cab [5];
        logic [7:0] got;
        cab[0] = {coin, 4'hf, cab_1p};
        cab[1] = {2'b11, joystick1};
        cab[2] = {2'b11, joystick2};
        cab[3] = dipsw_a;
        cab[4] = dipsw_b;
        bus_access(16'h5a17, 1'b0, 8'h00, got);
        check("rom read", rom_data, got);
        bus_access(16'hd123, 1'b0, 8'h00, got);
        check("char read", char_dout, got);
        bus_access(16'hdc40, 1'b0, 8'h00, got);
        check("scroll read", scr_dout, got);
        for (int i = 0; i < 8; i++) begin
            bus_access(16'hc000 + 16'(i), 1'b0, 8'h00, got);
            check($sformatf("cabinet %0d", i), (i < 5) ? cab[i] : 8'hff, got);
        end
    endtask

    // LHBL rise samples the PROM and H1 rises two clocks later
    task automatic run_line(input logic [7:0] line);
        @(negedge clk);
        v_count = line;
        lhbl    = 1'b1;
        repeat (2) @(negedge clk);
        h1 = 1'b1;
        @(negedge clk);
        lhbl = 1'b0;
        h1   = 1'b0;
    endtask

    task automatic watch_int(input int limit, output logic fell);
        fell = 1'b0;
        for (int n = 0; n < limit && !fell; n++) begin
            @(negedge clk);
            fell = !int_n;
        end
    endtask

    task automatic interrupts;
        logic [3:0] ent_a;
        logic [3:0] ent_b;
        logic       fell;
        ent_a = {2'b10, 2'($urandom)}; // Main irq without sound irq
        ent_b = {2'b11, 2'($urandom)};
        @(negedge clk);
        prom_we   = 1'b1;
        prog_addr = 8'h20;
        prog_din  = ent_a;
        @(negedge clk);
        prog_addr = 8'h21;
        prog_din  = ent_b;
        @(negedge clk);
        prom_we = 1'b0;
        run_line(8'h20);
        watch_int(20, fell);
        if (!fell) begin
            errors++;
            $display("Timeout: int_n did not fall after a line with the irq bit set");
        end
        check("snd_int", ent_a[2], snd_int);
        @(negedge clk);
        iorq_n = 1'b0;
        m1_n   = 1'b0;
        repeat (3) @(negedge clk);
        check("ack vector", {3'b110, ent_a[1:0], 3'b111}, cpu_din);
        check("int_n after ack", 1'b1, int_n);
        iorq_n    = 1'b1;
        m1_n      = 1'b1;
        dip_pause = 1'b0;
        run_line(8'h21);
        watch_int(12, fell);
        check("int_n fall while paused", 1'b0, fell);
        check("snd_int while paused", ent_b[2], snd_int);
    endtask

// File: testbench/main_glue_tb.sv
/* Main CPU bus glue testbench */
`timescale 1ns/1ps
`include "main_cfg.svh"

module main_glue_tb;

    logic        clk, rst, cpu_cen;
    logic [15:0] addr;
    logic        mreq_n, rfsh_n, iorq_n, m1_n, wr_n;
    logic [7:0]  cpu_dout, cpu_din, snd_latch, obj_dout;
    logic [7:0]  char_dout, scr_dout, rom_data, dipsw_a, dipsw_b;
    logic        int_n, flip, sres_b, nmi_mask, snd_int, okout, char_cs, scr_cs;
    logic [10:0] scr_hpos, scr_vpos;
    logic        blcnten, lhbl, h1, prom_we, dip_pause;
    logic [8:0]  obj_addr;
    logic [`MAIN_PROM_AW-1:0] v_count, prog_addr;
    logic [3:0]  prog_din;
    logic [1:0]  coin, cab_1p;
    logic [5:0]  joystick1, joystick2;
    int unsigned seed_val;
    int          checks;
    int          errors;

    main_glue dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    `include "main_glue_tests.svh"

    initial begin
        seed_val = $urandom(32'ha317_a746);
        checks   = 0;
        errors   = 0;
        // Bus idle, reset held, pause switch off
        {rst, cpu_cen, mreq_n, rfsh_n, iorq_n, m1_n, wr_n, dip_pause} = '1;
        {addr, cpu_dout, blcnten, obj_addr, lhbl, h1, prom_we} = '0;
        {v_count, prog_addr, prog_din} = '0;
        {char_dout, scr_dout, rom_data} = 24'($urandom);
        {coin, cab_1p, joystick1, joystick2, dipsw_a, dipsw_b} = $urandom;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        reset_defaults;
        reg_writes;
        ram_access;
        read_mux;
        interrupts;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src/main_glue.sv
/* Main CPU bus glue */
`timescale 1ns/1ps
`include "main_cfg.svh"

module main_glue (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cpu_cen,
    // Z80 bus
    input  main_bus_pkg::cpu_addr_t     addr,
    input  logic                        mreq_n,
    input  logic                        rfsh_n,
    input  logic                        iorq_n,
    input  logic                        m1_n,
    input  logic                        wr_n,
    input  main_bus_pkg::cpu_data_t     cpu_dout,
    output main_bus_pkg::cpu_data_t     cpu_din,
    output logic                        int_n,
    // Control outputs
    output logic                        flip,
    output logic                        sres_b,
    output logic                        nmi_mask,
    output logic                        snd_int,
    output logic                        okout,
    output main_bus_pkg::cpu_data_t     snd_latch,
    output main_video_pkg::scroll_pos_t scr_hpos,
    output main_video_pkg::scroll_pos_t scr_vpos,
    // Video RAM
    output logic                        char_cs,
    output logic                        scr_cs,
    input  main_bus_pkg::cpu_data_t     char_dout,
    input  main_bus_pkg::cpu_data_t     scr_dout,
    input  main_bus_pkg::cpu_data_t     rom_data,
    // Object scan
    input  logic                        blcnten,
    input  main_video_pkg::obj_addr_t   obj_addr,
    output main_bus_pkg::cpu_data_t     obj_dout,
    // Timing and PROM load
    input  logic                        lhbl,
    input  logic                        h1,
    input  logic [`MAIN_PROM_AW-1:0]    v_count,
    input  logic [`MAIN_PROM_AW-1:0]    prog_addr,
    input  main_video_pkg::prom_entry_t prog_din,
    input  logic                        prom_we,
    // Cabinet
    input  logic                        dip_pause,
    input  logic [1:0]                  coin,
    input  logic [1:0]                  cab_1p,
    input  logic [5:0]                  joystick1,
    input  logic [5:0]                  joystick2,
    input  main_bus_pkg::cpu_data_t     dipsw_a,
    input  main_bus_pkg::cpu_data_t     dipsw_b
);
    import main_bus_pkg::*;

    bus_region_t region;
    cpu_data_t   ram_dout;
    cpu_data_t   vector;
    cpu_data_t   cab_input [5];
    logic        iack;

    assign iack    = !iorq_n && !m1_n; // IM0 acknowledge cycle
    assign char_cs = (region == rgn_char);
    assign scr_cs  = (region == rgn_scroll);
    assign obj_dout = ram_dout;

    assign cab_input[0] = {coin, 4'hf, cab_1p}; // Coins and start
    assign cab_input[1] = {2'b11, joystick1};
    assign cab_input[2] = {2'b11, joystick2};
    assign cab_input[3] = dipsw_a;
    assign cab_input[4] = dipsw_b;

    main_decoder u_decoder (
        .addr   (addr),
        .mreq_n (mreq_n),
        .rfsh_n (rfsh_n),
        .wr_n   (wr_n),
        .region (region),
        .okout  (okout)
    );

    main_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .region    (region),
        .wr_n      (wr_n),
        .addr_low  (addr[1:0]),
        .din       (cpu_dout),
        .flip      (flip),
        .sres_b    (sres_b),
        .nmi_mask  (nmi_mask),
        .snd_latch (snd_latch),
        .scr_hpos  (scr_hpos),
        .scr_vpos  (scr_vpos)
    );

    main_ram u_ram (
        .clk      (clk),
        .cpu_cen  (cpu_cen),
        .region   (region),
        .wr_n     (wr_n),
        .cpu_addr (addr[`MAIN_RAM_AW-1:0]),
        .din      (cpu_dout),
        .blcnten  (blcnten),
        .obj_addr (obj_addr),
        .ram_dout (ram_dout)
    );

    main_irq u_irq (
        .clk       (clk),
        .rst       (rst),
        .lhbl      (lhbl),
        .h1        (h1),
        .v_count   (v_count),
        .prog_addr (prog_addr),
        .prog_din  (prog_din),
        .prom_we   (prom_we),
        .iack      (iack),
        .dip_pause (dip_pause),
        .int_n     (int_n),
        .snd_int   (snd_int),
        .vector    (vector)
    );

    main_din_mux u_din_mux (
        .clk       (clk),
        .region    (region),
        .cab_sel   (addr[2:0]),
        .iack      (iack),
        .vector    (vector),
        .ram_dout  (ram_dout),
        .char_dout (char_dout),
        .scr_dout  (scr_dout),
        .rom_data  (rom_data),
        .cab_input (cab_input),
        .cpu_din   (cpu_din)
    );

endmodule

// File: src/main_din_mux.sv
/* CPU read data selection */
`timescale 1ns/1ps

module main_din_mux (
    input  logic                      clk,
    input  main_bus_pkg::bus_region_t region,
    input  logic [2:0]                cab_sel,
    input  logic                      iack,
    input  main_bus_pkg::cpu_data_t   vector,
    input  main_bus_pkg::cpu_data_t   ram_dout,
    input  main_bus_pkg::cpu_data_t   char_dout,
    input  main_bus_pkg::cpu_data_t   scr_dout,
    input  main_bus_pkg::cpu_data_t   rom_data,
    input  main_bus_pkg::cpu_data_t   cab_input [5],
    output main_bus_pkg::cpu_data_t   cpu_din
);
    import main_bus_pkg::*;

    bus_region_t region_q;
    logic [2:0]  sel_q;
    logic        iack_q;
    cpu_data_t   cab_byte;

    // Align selection with the one cycle RAM read
    always_ff @(posedge clk) begin
        region_q <= region;
        sel_q    <= cab_sel;
        iack_q   <= iack;
    end

    always_comb begin
        case (sel_q)
            3'd0, 3'd1, 3'd2, 3'd3, 3'd4: cab_byte = cab_input[sel_q];
            default: cab_byte = 8'hff; // Open bus
        endcase
    end

    always_ff @(posedge clk) begin
        if (iack_q) begin
            cpu_din <= vector; // Acknowledge wins
        end else begin
            case (region_q)
                rgn_ram:    cpu_din <= ram_dout;
                rgn_char:   cpu_din <= char_dout;
                rgn_scroll: cpu_din <= scr_dout;
                rgn_rom:    cpu_din <= rom_data;
                rgn_inputs: cpu_din <= cab_byte;
                default:    cpu_din <= 8'hff;
            endcase
        end
    end

endmodule

// File: src/main_irq.sv
/* Interrupt generator */
`timescale 1ns/1ps
`include "main_cfg.svh"

module main_irq (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        lhbl,
    input  logic                        h1,
    input  logic [`MAIN_PROM_AW-1:0]    v_count,
    input  logic [`MAIN_PROM_AW-1:0]    prog_addr,
    input  main_video_pkg::prom_entry_t prog_din,
    input  logic                        prom_we,
    input  logic                        iack,
    input  logic                        dip_pause,
    output logic                        int_n,
    output logic                        snd_int,
    output main_bus_pkg::cpu_data_t     vector
);
    import main_video_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_sampled, // Entry taken until H1
        st_pending  // Main irq to be raised
    } irq_state_t;

    prom_entry_t prom [2**`MAIN_PROM_AW];
    prom_entry_t entry;
    irq_state_t  state;
    logic        lhbl_last;
    logic        h1_last;
    logic        lhbl_rise;
    logic        h1_rise;

    // Loaded at start-up
    always_ff @(posedge clk) begin
        if (prom_we) begin
            prom[prog_addr] <= prog_din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_last <= 1'b0;
            h1_last   <= 1'b0;
        end else begin
            lhbl_last <= lhbl;
            h1_last   <= h1;
        end
    end

    assign lhbl_rise = lhbl && !lhbl_last;
    assign h1_rise   = h1 && !h1_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            entry   <= '0;
            int_n   <= 1'b1;
            snd_int <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (lhbl_rise) begin
                        entry <= prom[v_count];
                        state <= st_sampled;
                    end
                end
                st_sampled: begin
                    if (h1_rise) begin
                        snd_int <= entry[2]; // Sound CPU irq line
                        state   <= (entry[3] && dip_pause) ? st_pending : st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
            if (iack) begin
                int_n <= 1'b1;
            end else if (state == st_pending) begin
                int_n <= 1'b0;
            end
        end
    end

    // RST instruction opcode for IM0
    assign vector = {3'b110, entry[1:0], 3'b111};

    // Main irq trails a qualifying H1 rise by two edges
    a_int_after_h1: assert property (
        @(posedge clk) disable iff (rst)
        $fell(int_n) |-> $past(h1_rise && entry[3] && dip_pause, 2)
    ) else $error("int_n fell without a qualifying H1 rise");

endmodule

// File: src/main_ram.sv
/* Shared work RAM */
`timescale 1ns/1ps
`include "main_cfg.svh"

module main_ram (
    input  logic                      clk,
    input  logic                      cpu_cen,
    input  main_bus_pkg::bus_region_t region,
    input  logic                      wr_n,
    input  main_video_pkg::ram_addr_t cpu_addr,
    input  main_bus_pkg::cpu_data_t   din,
    input  logic                      blcnten,
    input  main_video_pkg::obj_addr_t obj_addr,
    output main_bus_pkg::cpu_data_t   ram_dout
);
    import main_bus_pkg::*;
    import main_video_pkg::*;

    // Object scan is confined to the top page
    localparam int PAGE_W = `MAIN_RAM_AW - $bits(obj_addr_t);

    cpu_data_t mem [2**`MAIN_RAM_AW];
    ram_addr_t ram_addr;
    logic      cpu_we;
    logic      ram_we;

    assign cpu_we   = cpu_cen && region == rgn_ram && !wr_n;
    assign ram_addr = blcnten ? {{PAGE_W{1'b1}}, obj_addr} : cpu_addr;
    assign ram_we   = cpu_we && !blcnten; // Line buffer time owns the RAM

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_addr] <= din;
        end
        ram_dout <= mem[ram_addr];
    end

endmodule

// File: src/main_regs.sv
/* CPU write registers */
`timescale 1ns/1ps
`include "main_cfg.svh"

module main_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cpu_cen,
    input  main_bus_pkg::bus_region_t   region,
    input  logic                        wr_n,
    input  logic [1:0]                  addr_low,
    input  main_bus_pkg::cpu_data_t     din,
    output logic                        flip,
    output logic                        sres_b,
    output logic                        nmi_mask,
    output main_bus_pkg::cpu_data_t     snd_latch,
    output main_video_pkg::scroll_pos_t scr_hpos,
    output main_video_pkg::scroll_pos_t scr_vpos
);
    import main_bus_pkg::*;
    import main_video_pkg::*;

    localparam int POS_W = $bits(scroll_pos_t);

    logic wr_en;

    assign wr_en = cpu_cen && !wr_n;

    // Misc control and sound latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip      <= 1'b0;
            sres_b    <= 1'b1;
            nmi_mask  <= 1'b0;
            snd_latch <= '0;
        end else if (wr_en) begin
            if (region == rgn_misc) begin
                flip     <= din[`MAIN_FLIP_BIT];
                sres_b   <= ~din[`MAIN_SRES_BIT]; // Inverted on the board
                nmi_mask <= din[`MAIN_NMI_BIT];
            end
            if (region == rgn_snd_latch) begin
                snd_latch <= din;
            end
        end
    end

    // Scroll position, four byte ports
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scr_hpos <= '0;
            scr_vpos <= '0;
        end else if (wr_en && region == rgn_scroll_pos) begin
            case (addr_low)
                2'd0: scr_hpos[7:0] <= din;
                2'd1: begin
                    scr_hpos[8]         <= din[0];
                    scr_hpos[POS_W-1:9] <= '0; // Upper bits unused on this map
                end
                2'd2: scr_vpos[7:0] <= din;
                default: begin
                    scr_vpos[8]         <= din[0];
                    scr_vpos[POS_W-1:9] <= '0;
                end
            endcase
        end
    end

endmodule

// File: src/main_decoder.sv
/* Main CPU address decoder */
`timescale 1ns/1ps

module main_decoder (
    input  main_bus_pkg::cpu_addr_t   addr,
    input  logic                      mreq_n,
    input  logic                      rfsh_n,
    input  logic                      wr_n,
    output main_bus_pkg::bus_region_t region,
    output logic                      okout
);
    import main_bus_pkg::*;

    always_comb begin
        region = rgn_none;
        // Refresh cycles never decode
        if (!mreq_n && rfsh_n) begin
            casez (addr[15:13])
                3'b0??, 3'b10?: region = rgn_rom; // 48 kB
                3'b110: begin
                    case (addr[12:11])
                        2'b00: region = rgn_inputs;
                        2'b01: begin
                            // Control ports are write only
                            if (!wr_n) begin
                                casez (addr[3:0])
                                    4'b0000: region = rgn_snd_latch;
                                    4'b0100: region = rgn_misc;
                                    4'b0110: region = rgn_okout;
                                    4'b10??: region = rgn_scroll_pos;
                                    default: region = rgn_none;
                                endcase
                            end
                        end
                        2'b10: region = rgn_char;
                        default: region = rgn_scroll;
                    endcase
                end
                default: region = rgn_ram; // E000-FFFF
            endcase
        end
    end

    assign okout = (region == rgn_okout);

endmodule

// File: src/main_video_pkg.sv
/* Video side types */
`include "main_cfg.svh"

package main_video_pkg;

    typedef logic [10:0] scroll_pos_t;
    typedef logic [`MAIN_RAM_AW-1:0] ram_addr_t;

    // Object engine scan address, lands in the top RAM page
    typedef logic [8:0] obj_addr_t;

    // Bit 3 main irq, bit 2 sound irq, bits 1:0 vector field
    typedef logic [3:0] prom_entry_t;

endpackage

// File: src/main_bus_pkg.sv
/* Main CPU bus types */
package main_bus_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // Decoded bus regions of the Commando map
    typedef enum logic [3:0] {
        rgn_none,
        rgn_rom,        // 0000-BFFF
        rgn_ram,        // E000-FFFF
        rgn_inputs,     // C000-C7FF
        rgn_char,       // D000-D7FF
        rgn_scroll,     // D800-DFFF
        rgn_snd_latch,  // C800 write
        rgn_misc,       // C804 write
        rgn_scroll_pos, // C808-C80B write
        rgn_okout       // C806 write
    } bus_region_t;

endpackage

// File: src/main_cfg.svh
/* Main CPU bus glue configuration */
`ifndef MAIN_CFG_SVH
`define MAIN_CFG_SVH

// Work RAM, 8 kB
`define MAIN_RAM_AW 13

// Vertical timing PROM, one entry per line
`define MAIN_PROM_AW 8

// Misc register at C804
`define MAIN_FLIP_BIT 7
`define MAIN_SRES_BIT 4
`define MAIN_NMI_BIT 3

`endif
